//--- Makefile
VERILATOR ?= verilator
TOP       ?= rvExecPipeTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

# A failing run exits non zero, so make fails too
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- build.f
src/rvIsaPkg.sv
src/rvPipePkg.sv
src/rvDecode.sv
src/rvAlu.sv
src/rvWriteback.sv
src/rvExecPipe.sv
dv/rvExecPipeTb.sv

//--- dv/rvExecPipeTb.sv
// Random instruction test of rvExecPipe at pcWidth 24, fixed seed
// About 2000 instructions with gaps and back-to-back bursts, checked in order
// Needs a simulator with timing support for the delay based clock
`timescale 1ns/1ps

module rvExecPipeTb;

   localparam int          pcWidth    = 24;
   localparam int          numInstr   = 2000;
   localparam int          cycleLimit = 4 * numInstr + 100;
   localparam logic [31:0] pcMask     = 32'((64'd1 << pcWidth) - 64'd1);
   localparam logic [24:0] badOps     = {5'b00000, 5'b01000, 5'b11100, 5'b00011, 5'b01110};
   localparam logic [17:0] brCodes    = {3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

   typedef struct packed {
      rvPipePkg::retireT res;
      logic [31:0]       due;   // Negedge count when it must retire
      logic [2:0]        kind;  // Test group of the instruction
   } expectT;

   logic              clk = 1'b0;
   logic              reset;
   logic              inValid;
   rvPipePkg::issueT  inOp;
   logic              outValid;
   rvPipePkg::retireT outRes;
   expectT            expQ[$];
   expectT            front;
   int                cycleCount = 0;

   rvExecPipe #(.pcWidth(pcWidth)) u_dut (
      .clk      (clk),
      .reset    (reset),
      .inValid  (inValid),
      .inOp     (inOp),
      .outValid (outValid),
      .outRes   (outRes)
   );

   always #4 clk = ~clk; // 8 ns period

   task automatic stopRun(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected) begin
         $display("FAIL %s expected %h actual %h", name, expected, actual);
         stopRun("Value mismatch");
      end
   endtask

   function automatic string kindName(input logic [2:0] kind);
      case (kind)
         3'd0:    return "alu";
         3'd1:    return "mul";
         3'd2:    return "upper imm";
         3'd3:    return "control flow";
         default: return "illegal";
      endcase
   endfunction

   // RV32I register and immediate ops
   function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
      logic [31:0] res;
      case (f3)
         3'd0: res = alt ? x - y : x + y;
         3'd1: res = x << y[4:0];
         3'd2: res = {31'd0, $signed(x) < $signed(y)};
         3'd3: res = {31'd0, x < y};
         3'd4: res = x ^ y;
         3'd5: begin
            if (alt) res = $signed(x) >>> y[4:0]; // SRA keeps the sign
            else     res = x >> y[4:0];
         end
         3'd6: res = x | y;
         default: res = x & y;
      endcase
      return res;
   endfunction

   // Full 64-bit product with each operand extended per variant
   function automatic logic [31:0] mulModel(input logic [1:0] sel, input logic [31:0] x,
                                            input logic [31:0] y);
      logic [63:0] p;
      case (sel)
         2'd1:    p = {{32{x[31]}}, x} * {{32{y[31]}}, y}; // MULH
         2'd2:    p = {{32{x[31]}}, x} * {32'd0, y};       // MULHSU
         default: p = {32'd0, x} * {32'd0, y};             // MUL low word, MULHU
      endcase
      return (sel == 2'd0) ? p[31:0] : p[63:32];
   endfunction

   function automatic rvPipePkg::retireT expectRetire(input rvPipePkg::issueT op);
      rvPipePkg::retireT r;
      logic [31:0]       instr, a, b, pc, pc4, iImm, uImm, jImm, bImm, data, nxt;
      logic [2:0]        f3;
      logic              legal, write, taken;
      instr = op.instr;
      a     = op.rs1Val;
      b     = op.rs2Val;
      f3    = instr[14:12];
      iImm  = {{20{instr[31]}}, instr[31:20]};
      uImm  = {instr[31:12], 12'h000};
      jImm  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      bImm  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      pc    = op.pc & pcMask;            // PC wraps at pcWidth
      pc4   = (pc + 32'd4) & pcMask;
      legal = (instr[1:0] == 2'b11);     // Compressed forms are illegal
      write = 1'b1;
      data  = 32'd0;
      nxt   = pc4;
      taken = 1'b0;
      case (instr[6:2])
         5'b00100: data = aluModel(f3, f3 == 3'd5 && instr[30], a, iImm); // OP-IMM
         5'b01100: begin                                                  // OP
            if (instr[31:25] == 7'h01) begin
               legal = legal && !f3[2];  // No divider
               data  = mulModel(f3[1:0], a, b);
            end else begin
               data = aluModel(f3, instr[30], a, b);
            end
         end
         5'b01101: data = uImm;                       // LUI
         5'b00101: data = (pc + uImm) & pcMask;       // AUIPC
         5'b11011: begin                              // JAL
            data = pc4;
            nxt  = (pc + jImm) & pcMask;
         end
         5'b11001: begin                              // JALR
            data = pc4;
            nxt  = (a + iImm) & pcMask & ~32'd1;
         end
         5'b11000: begin                              // Branch
            write = 1'b0;
            case (f3)
               3'd0:    taken = (a == b);
               3'd1:    taken = (a != b);
               3'd4:    taken = $signed(a) < $signed(b);
               3'd5:    taken = $signed(a) >= $signed(b);
               3'd6:    taken = (a < b);
               default: taken = (a >= b);
            endcase
            if (taken) nxt = (pc + bImm) & pcMask;
         end
         default: legal = 1'b0;
      endcase
      r.rd      = instr[11:7];
      r.illegal = !legal;
      r.wrEn    = legal && write && (instr[11:7] != 5'd0);
      r.wrData  = legal ? data : 32'd0;
      r.nextPc  = legal ? nxt : pc4;
      return r;
   endfunction

   function automatic logic [31:0] pickOperand();
      case ($urandom_range(0, 5))
         0:       return 32'h0000_0000;
         1:       return 32'h8000_0000;
         2:       return 32'hffff_ffff;
         default: return $urandom();
      endcase
   endfunction

   // Random instruction from the raw word, then fixed fields per group
   task automatic makeIssue(output rvPipePkg::issueT op, output logic [2:0] kind);
      logic [31:0] instr;
      int          sel;
      instr = $urandom();
      sel   = $urandom_range(0, 8);
      kind  = 3'd0;
      case (sel)
         0: begin
            instr[6:0] = 7'h13;
            if (instr[13:12] == 2'b01)   // Shifts take only SRAI's funct7
               instr[31:25] = (instr[14] && instr[30]) ? 7'h20 : 7'h00;
         end
         1: begin
            instr[6:0]   = 7'h33;
            instr[31:25] = (instr[14:12] == 3'd0 || instr[14:12] == 3'd5) && instr[30]
                           ? 7'h20 : 7'h00;
         end
         2: begin
            instr[6:0]   = 7'h33;
            instr[31:25] = 7'h01;
            kind         = instr[14] ? 3'd4 : 3'd1; // Divide codes are illegal
         end
         3: begin
            instr[6:0] = 7'h37;
            kind       = 3'd2;
         end
         4: begin
            instr[6:0] = 7'h17;
            kind       = 3'd2;
         end
         5: begin
            instr[6:0] = 7'h6f;
            kind       = 3'd3;
         end
         6: begin
            instr[6:0]   = 7'h67;
            instr[14:12] = 3'd0;
            kind         = 3'd3;
         end
         7: begin
            instr[6:0]   = 7'h63;
            instr[14:12] = brCodes[3 * $urandom_range(0, 5) +: 3];
            kind         = 3'd3;
         end
         default: begin
            if (instr[0]) instr[1:0] = 2'($urandom_range(0, 2)); // Compressed
            else          instr[6:0] = {badOps[5 * $urandom_range(0, 4) +: 5], 2'b11};
            kind = 3'd4;
         end
      endcase
      op.instr  = instr;
      op.rs1Val = pickOperand();
      op.rs2Val = ($urandom_range(0, 3) == 0) ? op.rs1Val : pickOperand(); // Equal often
      op.pc     = $urandom();
      if ($urandom_range(0, 3) == 0) op.pc[23:4] = '1; // Close to the wrap
   endtask

   always @(negedge clk) begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         stopRun("Timeout, the cycle limit was reached before the run ended");
      end else if (outValid === 1'b1) begin
         if (expQ.size() == 0) begin
            stopRun("outValid went high with no instruction in flight");
         end else begin
            front = expQ.pop_front();
            checkValue({kindName(front.kind), " latency"}, front.due, 32'(cycleCount));
            checkValue({kindName(front.kind), " wrEn"}, 32'(front.res.wrEn), 32'(outRes.wrEn));
            checkValue({kindName(front.kind), " rd"}, 32'(front.res.rd), 32'(outRes.rd));
            checkValue({kindName(front.kind), " wrData"}, front.res.wrData, outRes.wrData);
            checkValue({kindName(front.kind), " nextPc"}, front.res.nextPc, outRes.nextPc);
            checkValue({kindName(front.kind), " illegal"}, 32'(front.res.illegal),
                       32'(outRes.illegal));
         end
      end else if (outValid !== 1'b0) begin
         stopRun("outValid is unknown");
      end else if (expQ.size() != 0 && expQ[0].due < cycleCount) begin
         stopRun("An issued instruction did not retire on time");
      end
   end

   initial begin
      int               issued;
      int               burstLeft;
      logic             goNow;
      logic [2:0]       kind;
      rvPipePkg::issueT op;
      expectT           e;
      void'($urandom(32'hecbfa655));
      reset     = 1'b0;
      inValid   = 1'b0;
      inOp      = '0;
      issued    = 0;
      burstLeft = 0;
      repeat (2) @(posedge clk);
      reset <= 1'b1;
      @(negedge clk);
      checkValue("reset outValid", 32'd0, 32'(outValid));
      while (issued < numInstr) begin
         @(posedge clk);
         if (burstLeft == 0 && $urandom_range(0, 15) == 0)
            burstLeft = $urandom_range(20, 60);  // Long back-to-back run
         goNow = (burstLeft > 0) || ($urandom_range(0, 1) == 1);
         if (burstLeft > 0) burstLeft--;
         if (goNow) begin
            makeIssue(op, kind);
            e.res  = expectRetire(op);
            e.due  = cycleCount + 4; // Sampled next edge, three stages, seen at negedge
            e.kind = kind;
            expQ.push_back(e);
            inOp    <= op;
            inValid <= 1'b1;
            issued++;
         end else begin
            inValid <= 1'b0;
         end
      end
      @(posedge clk);
      inValid <= 1'b0;
      repeat (5) @(negedge clk); // Past the fixed latency
      if (expQ.size() == 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         stopRun("Instructions were issued but never retired");
      end
   end

endmodule

//--- src/rvAlu.sv
// Execute stage, one cycle; every class result is computed and write-back picks one
// PC candidates wrap at pcWidth bits and are zero padded to 32
// Branches compare rs1 with rs2 since useImm is clear for them
`timescale 1ns/1ps

module rvAlu #(
   parameter int pcWidth = 24
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                decValid,
   input  rvPipePkg::decodedT  decOp,
   output logic                exValid,
   output rvPipePkg::execT     exOp
);

   localparam int padWidth = rvIsaPkg::xlen - pcWidth;

   logic [31:0]         in1, in2;
   logic [31:0]         sum;
   logic [32:0]         minus;
   logic                lt, ltu, eq;
   logic [31:0]         shIn, shifter, leftShift;
   logic signed [32:0]  shExt;
   logic                isMulh, isMulhsu;
   logic signed [32:0]  signed1, signed2;
   logic signed [65:0]  product;
   logic [31:0]         aluOut;
   logic                predicate;
   logic [pcWidth-1:0]  pcPlus4, pcPlusImm, jalrSum;
   rvPipePkg::execT     nextEx;

   function automatic logic [31:0] bitRev(input logic [31:0] v);
      logic [31:0] r;
      for (int i = 0; i < 32; i++) r[i] = v[31-i];
      return r;
   endfunction

   assign in1 = decOp.rs1Val;
   assign in2 = decOp.useImm ? decOp.imm : decOp.rs2Val;

   assign sum   = in1 + in2;
   // One 33-bit subtract serves SUB and every compare
   assign minus = {1'b1, ~in2} + {1'b0, in1} + 33'b1;
   assign ltu   = minus[32];
   assign lt    = (in1[31] ^ in2[31]) ? in1[31] : minus[32];
   assign eq    = (minus[31:0] == 32'b0);

   // Right shifter only, left shifts go through bit reversal
   assign shIn      = (decOp.funct3 == rvIsaPkg::f3Sll) ? bitRev(in1) : in1;
   assign shExt     = $signed({decOp.alt & in1[31], shIn}) >>> in2[4:0];
   assign shifter   = shExt[31:0];
   assign leftShift = bitRev(shifter);

   always_comb begin
      case (decOp.funct3)
         rvIsaPkg::f3AddSub: aluOut = decOp.alt ? minus[31:0] : sum;
         rvIsaPkg::f3Sll:    aluOut = leftShift;
         rvIsaPkg::f3Slt:    aluOut = {31'b0, lt};
         rvIsaPkg::f3Sltu:   aluOut = {31'b0, ltu};
         rvIsaPkg::f3Xor:    aluOut = in1 ^ in2;
         rvIsaPkg::f3Srl:    aluOut = shifter;      // SRL or SRA by alt
         rvIsaPkg::f3Or:     aluOut = in1 | in2;
         default:            aluOut = in1 & in2;
      endcase
   end

   // 33x33 signed multiply, sign bits chosen per variant
   assign isMulh   = (decOp.funct3 == 3'd1);
   assign isMulhsu = (decOp.funct3 == 3'd2);
   assign signed1  = {in1[31] & (isMulh | isMulhsu), in1}; // rs1 signed for MULH, MULHSU
   assign signed2  = {in2[31] & isMulh, in2};              // rs2 signed for MULH only
   assign product  = signed1 * signed2;

   always_comb begin
      case (decOp.funct3)
         rvIsaPkg::f3Beq:  predicate = eq;
         rvIsaPkg::f3Bne:  predicate = !eq;
         rvIsaPkg::f3Blt:  predicate = lt;
         rvIsaPkg::f3Bge:  predicate = !lt;
         rvIsaPkg::f3Bltu: predicate = ltu;
         rvIsaPkg::f3Bgeu: predicate = !ltu;
         default:          predicate = 1'b0; // Undefined codes never taken
      endcase
   end

   // PC adders at pcWidth, the immediate already matches the class
   assign pcPlus4   = decOp.pc[pcWidth-1:0] + pcWidth'(4);
   assign pcPlusImm = decOp.pc[pcWidth-1:0] + decOp.imm[pcWidth-1:0];
   assign jalrSum   = decOp.rs1Val[pcWidth-1:0] + decOp.imm[pcWidth-1:0];

   always_comb begin
      nextEx            = '0;
      nextEx.opClass    = decOp.opClass;
      nextEx.rd         = decOp.rd;
      nextEx.aluRes     = aluOut;
      nextEx.mulRes     = (decOp.funct3 == 3'd0) ? product[31:0] : product[63:32];
      nextEx.predicate  = predicate;
      nextEx.pcPlusImm  = {{padWidth{1'b0}}, pcPlusImm};
      nextEx.jalrTarget = {{padWidth{1'b0}}, jalrSum[pcWidth-1:1], 1'b0}; // Bit 0 cleared
      nextEx.pcPlus4    = {{padWidth{1'b0}}, pcPlus4};
      nextEx.immVal     = decOp.imm;                    // LUI value
   end

   always_ff @(posedge clk) begin
      if (!reset) exValid <= 1'b0;
      else        exValid <= decValid;
   end

   always_ff @(posedge clk) begin
      if (decValid) exOp <= nextEx;
   end

endmodule

//--- src/rvDecode.sv
// Decode stage, one cycle; compressed encodings and unknown opcodes become clsIllegal
// DIV, DIVU, REM and REMU are illegal as there is no divider
// The PC is cut to pcWidth bits here and travels zero padded
`timescale 1ns/1ps

module rvDecode #(
   parameter int pcWidth = 24
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                inValid,
   input  rvPipePkg::issueT    inOp,
   output logic                decValid,
   output rvPipePkg::decodedT  decOp
);

   localparam int padWidth = rvIsaPkg::xlen - pcWidth;

   logic [31:0]          instr;
   logic [4:0]           opcode;
   logic [2:0]           funct3;
   logic [6:0]           funct7;
   logic [31:0]          iImm, uImm, jImm, bImm;
   rvPipePkg::decodedT   nextDec;

   assign instr  = inOp.instr;
   assign opcode = instr[6:2];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   // Immediate formats
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign uImm = {instr[31:12], 12'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

   always_comb begin
      nextDec        = '0;
      nextDec.funct3 = funct3;
      nextDec.rd     = instr[11:7];
      nextDec.pc     = {{padWidth{1'b0}}, inOp.pc[pcWidth-1:0]};
      nextDec.rs1Val = inOp.rs1Val;
      nextDec.rs2Val = inOp.rs2Val;
      nextDec.imm    = iImm;                 // ALU imm forms and JALR
      nextDec.useImm = (opcode == rvIsaPkg::opAluImm) || (opcode == rvIsaPkg::opJalr);
      // SUB only for reg-reg, ADDI bit 30 belongs to the immediate
      nextDec.alt    = (funct7 == rvIsaPkg::f7Alt) &&
                       (funct3 == rvIsaPkg::f3Srl ||
                        (opcode == rvIsaPkg::opAluReg && funct3 == rvIsaPkg::f3AddSub));
      case (opcode)
         rvIsaPkg::opAluImm: nextDec.opClass = rvPipePkg::clsAlu;
         rvIsaPkg::opAluReg: begin
            if (funct7 == rvIsaPkg::f7MulDiv)
               nextDec.opClass = funct3[2] ? rvPipePkg::clsIllegal  // Divide codes
                                           : rvPipePkg::clsMul;
            else
               nextDec.opClass = rvPipePkg::clsAlu;
         end
         rvIsaPkg::opLui: begin
            nextDec.opClass = rvPipePkg::clsLui;
            nextDec.imm     = uImm;
         end
         rvIsaPkg::opAuipc: begin
            nextDec.opClass = rvPipePkg::clsAuipc;
            nextDec.imm     = uImm;
         end
         rvIsaPkg::opJal: begin
            nextDec.opClass = rvPipePkg::clsJal;
            nextDec.imm     = jImm;
         end
         rvIsaPkg::opJalr: nextDec.opClass = rvPipePkg::clsJalr;
         rvIsaPkg::opBranch: begin
            nextDec.opClass = rvPipePkg::clsBranch;
            nextDec.imm     = bImm;
         end
         default: nextDec.opClass = rvPipePkg::clsIllegal;
      endcase
      if (instr[1:0] != 2'b11) nextDec.opClass = rvPipePkg::clsIllegal; // Compressed
   end

   always_ff @(posedge clk) begin
      if (!reset) decValid <= 1'b0;
      else        decValid <= inValid;
   end

   always_ff @(posedge clk) begin
      if (inValid) decOp <= nextDec; // Payload, no reset
   end

endmodule

//--- src/rvExecPipe.sv
// Three stage RV32IM integer execute path, fixed latency of 3 cycles
// Accepts one instruction per cycle, no back-pressure
// pcWidth sets the PC wrap width, 32 at most
`timescale 1ns/1ps

module rvExecPipe #(
   parameter int pcWidth = 24
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              inValid,
   input  rvPipePkg::issueT  inOp,
   output logic              outValid,
   output rvPipePkg::retireT outRes
);

   logic               decValid, exValid;
   rvPipePkg::decodedT decOp;
   rvPipePkg::execT    exOp;

   rvDecode #(.pcWidth(pcWidth)) u_decode (
      .clk      (clk),
      .reset    (reset),
      .inValid  (inValid),
      .inOp     (inOp),
      .decValid (decValid),
      .decOp    (decOp)
   );

   rvAlu #(.pcWidth(pcWidth)) u_alu (
      .clk      (clk),
      .reset    (reset),
      .decValid (decValid),
      .decOp    (decOp),
      .exValid  (exValid),
      .exOp     (exOp)
   );

   rvWriteback u_writeback (
      .clk      (clk),
      .reset    (reset),
      .exValid  (exValid),
      .exOp     (exOp),
      .outValid (outValid),
      .outRes   (outRes)
   );

endmodule

//--- src/rvIsaPkg.sv
// RV32I and RV32M encoding constants used by the execute pipeline
// Opcodes are given for instr[6:2] only; the two low bits must be 11
// Only the opcodes of the kept instruction groups are listed
package rvIsaPkg;

   localparam int xlen        = 32; // Data word width
   localparam int regIdxWidth = 5;  // Register index width

   // Major opcodes, instr[6:2]
   localparam logic [4:0] opAluImm = 5'b00100; // rd <- rs1 OP Iimm
   localparam logic [4:0] opAluReg = 5'b01100; // rd <- rs1 OP rs2
   localparam logic [4:0] opLui    = 5'b01101; // rd <- Uimm
   localparam logic [4:0] opAuipc  = 5'b00101; // rd <- PC + Uimm
   localparam logic [4:0] opJal    = 5'b11011; // rd <- PC + 4, PC <- PC + Jimm
   localparam logic [4:0] opJalr   = 5'b11001; // rd <- PC + 4, PC <- rs1 + Iimm
   localparam logic [4:0] opBranch = 5'b11000; // if (rs1 OP rs2) PC <- PC + Bimm

   // ALU funct3
   localparam logic [2:0] f3AddSub = 3'b000;
   localparam logic [2:0] f3Sll    = 3'b001;
   localparam logic [2:0] f3Slt    = 3'b010;
   localparam logic [2:0] f3Sltu   = 3'b011;
   localparam logic [2:0] f3Xor    = 3'b100;
   localparam logic [2:0] f3Srl    = 3'b101; // Also SRA with f7Alt
   localparam logic [2:0] f3Or     = 3'b110;
   localparam logic [2:0] f3And    = 3'b111;

   // Branch funct3, codes 2 and 3 are not defined
   localparam logic [2:0] f3Beq  = 3'b000;
   localparam logic [2:0] f3Bne  = 3'b001;
   localparam logic [2:0] f3Blt  = 3'b100;
   localparam logic [2:0] f3Bge  = 3'b101;
   localparam logic [2:0] f3Bltu = 3'b110;
   localparam logic [2:0] f3Bgeu = 3'b111;

   // funct7 markers
   localparam logic [6:0] f7MulDiv = 7'b0000001; // M extension group
   localparam logic [6:0] f7Alt    = 7'b0100000; // SUB and SRA

endpackage

//--- src/rvPipePkg.sv
// Types passed between the stages of the execute pipeline
// PC fields are 32 bits wide but only the low pcWidth bits are ever non zero
// Struct field order fixes the packed layout, keep it stable
package rvPipePkg;

   // Operation class, chosen in decode and carried to write-back
   typedef enum logic [2:0] {
      clsAlu     = 3'd0,
      clsMul     = 3'd1,
      clsLui     = 3'd2,
      clsAuipc   = 3'd3,
      clsJal     = 3'd4,
      clsJalr    = 3'd5,
      clsBranch  = 3'd6,
      clsIllegal = 3'd7
   } opClassT;

   // Issued instruction with its operands, 128 bits
   typedef struct packed {
      logic [rvIsaPkg::xlen-1:0] instr;
      logic [rvIsaPkg::xlen-1:0] pc;
      logic [rvIsaPkg::xlen-1:0] rs1Val;
      logic [rvIsaPkg::xlen-1:0] rs2Val;
   } issueT;

   // Decode stage output
   typedef struct packed {
      opClassT                          opClass;
      logic [2:0]                       funct3;
      logic                             alt;     // SUB or SRA
      logic [rvIsaPkg::regIdxWidth-1:0] rd;
      logic [rvIsaPkg::xlen-1:0]        imm;     // Format picked by class
      logic                             useImm;  // Second operand is imm
      logic [rvIsaPkg::xlen-1:0]        pc;
      logic [rvIsaPkg::xlen-1:0]        rs1Val;
      logic [rvIsaPkg::xlen-1:0]        rs2Val;
   } decodedT;

   // ALU stage output, every candidate result of the instruction
   typedef struct packed {
      opClassT                          opClass;
      logic [rvIsaPkg::regIdxWidth-1:0] rd;
      logic [rvIsaPkg::xlen-1:0]        aluRes;
      logic [rvIsaPkg::xlen-1:0]        mulRes;
      logic                             predicate;  // Branch taken
      logic [rvIsaPkg::xlen-1:0]        pcPlusImm;
      logic [rvIsaPkg::xlen-1:0]        jalrTarget;
      logic [rvIsaPkg::xlen-1:0]        pcPlus4;
      logic [rvIsaPkg::xlen-1:0]        immVal;
   } execT;

   // Retired record, 71 bits
   typedef struct packed {
      logic                             wrEn;
      logic [rvIsaPkg::regIdxWidth-1:0] rd;
      logic [rvIsaPkg::xlen-1:0]        wrData;
      logic [rvIsaPkg::xlen-1:0]        nextPc;
      logic                             illegal;
   } retireT;

endpackage

//--- src/rvWriteback.sv
// Write-back stage, one cycle; picks the result and next PC per class
// Illegal instructions retire with wrData 0 and fall through to PC + 4
`timescale 1ns/1ps

module rvWriteback (
   input  logic              clk,
   input  logic              reset,
   input  logic              exValid,
   input  rvPipePkg::execT   exOp,
   output logic              outValid,
   output rvPipePkg::retireT outRes
);

   rvPipePkg::retireT nextRes;
   logic              isIllegal, isBranch;

   assign isIllegal = (exOp.opClass == rvPipePkg::clsIllegal);
   assign isBranch  = (exOp.opClass == rvPipePkg::clsBranch);

   always_comb begin
      nextRes         = '0;
      nextRes.rd      = exOp.rd;
      nextRes.illegal = isIllegal;
      // No register write for branches, illegal ones or x0
      nextRes.wrEn    = !isBranch && !isIllegal && (exOp.rd != '0);
      case (exOp.opClass)
         rvPipePkg::clsAlu:   nextRes.wrData = exOp.aluRes;
         rvPipePkg::clsMul:   nextRes.wrData = exOp.mulRes;
         rvPipePkg::clsLui:   nextRes.wrData = exOp.immVal;
         rvPipePkg::clsAuipc: nextRes.wrData = exOp.pcPlusImm;
         rvPipePkg::clsJal,
         rvPipePkg::clsJalr:  nextRes.wrData = exOp.pcPlus4;  // Link value
         default:             nextRes.wrData = '0;
      endcase
      case (exOp.opClass)
         rvPipePkg::clsJal:    nextRes.nextPc = exOp.pcPlusImm;
         rvPipePkg::clsJalr:   nextRes.nextPc = exOp.jalrTarget;
         rvPipePkg::clsBranch: nextRes.nextPc = exOp.predicate ? exOp.pcPlusImm
                                                               : exOp.pcPlus4;
         default:              nextRes.nextPc = exOp.pcPlus4;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset) outValid <= 1'b0;
      else        outValid <= exValid;
   end

   always_ff @(posedge clk) begin
      if (exValid) outRes <= nextRes;
   end

endmodule
